/* logic/dbg_pkg.sv */
package dbg_pkg;

   ////////////////////////////////////////////////////////////
   // Widths fixed by the 64-bit command format
   localparam int DR_W      = 64;  // Shared TAP data register
   localparam int ADDR_W    = 32;
   localparam int DATA_W    = 64;
   localparam int CNT_W     = 16;  // Words per burst
   localparam int BIT_CNT_W = 6;   // Bits within one word
   localparam int CRC_W     = 32;

   localparam logic [CRC_W-1:0] CRC_POLY = 32'hEDB88320;  // CRC-32, reflected form
   localparam logic [CRC_W-1:0] CRC_INIT = '1;

   typedef logic [ADDR_W-1:0]    addr_t;      // Byte address on the bus
   typedef logic [DATA_W-1:0]    data_t;
   typedef logic [CNT_W-1:0]     word_cnt_t;
   typedef logic [BIT_CNT_W-1:0] bit_cnt_t;
   typedef logic [CRC_W-1:0]     crc_t;
   typedef logic [3:0]           size_t;      // 1, 2, 4 or 8 bytes

   typedef enum logic [3:0] {
      BWRITE8  = 4'h1,
      BWRITE16 = 4'h2,
      BWRITE32 = 4'h3,
      BWRITE64 = 4'h4,
      BREAD8   = 4'h5,
      BREAD16  = 4'h6,
      BREAD32  = 4'h7,
      BREAD64  = 4'h8
   } cmd_op_e;

   typedef enum logic [3:0] {
      IDLE, RBEGIN, RREADY, RSTATUS, RBURST, RCRC,
      WREADY, WWAIT, WBURST, WCRC, WMATCH
   } fsm_state_e;

   typedef enum logic [1:0] {STATUS, DATA, MATCH, CRC} tdo_sel_e;

   // Strobes from the burst FSM to the datapath
   typedef struct packed {
      logic     addr_ld;
      logic     addr_inc;
      logic     word_ld;
      logic     word_dec;
      logic     bit_inc;
      logic     bit_clr;
      logic     out_ld;
      logic     out_shift;
      logic     crc_clr;
      logic     crc_en;
      logic     crc_tdi_sel;  // 1 = write data from TDI, 0 = read data
      logic     crc_shift;
      logic     bus_strobe;
      tdo_sel_e tdo_sel;
   } ctrl_t;

   typedef struct packed {
      logic word_zero;
      logic last_word;
      logic bit_max;    // Last bit of the current word
      logic bit_32;
   } cnt_stat_t;

   typedef struct packed {
      addr_t addr;
      data_t wdata;  // Right-aligned
      size_t size;
      logic  write;
   } bus_req_t;

   function automatic size_t word_bytes(cmd_op_e op);
      case (op)
         BWRITE8, BREAD8:   return 4'd1;
         BWRITE16, BREAD16: return 4'd2;
         BWRITE32, BREAD32: return 4'd4;
         default:           return 4'd8;
      endcase
   endfunction

endpackage

/* logic/dbg_cmd_fsm.sv */
`timescale 1ns/1ns

module dbg_cmd_fsm (
   input  logic                     tck_i,
   input  logic                     trstn_i,
   input  logic                     module_select_i,
   input  logic                     capture_dr_i,
   input  logic                     update_dr_i,
   input  logic                     shift_dr_i,
   input  logic [dbg_pkg::DR_W-1:0] data_register_i,
   input  dbg_pkg::cnt_stat_t       stat_i,
   input  logic                     bus_rdy_i,
   output dbg_pkg::ctrl_t           ctrl_o,
   output dbg_pkg::cmd_op_e         op_o,
   output logic                     top_inhibit_o
);

   dbg_pkg::fsm_state_e state_q;
   dbg_pkg::fsm_state_e state_d;
   dbg_pkg::cmd_op_e    op_q;
   logic [3:0]          op_in;       // Opcode field of the DR
   logic                cmd_read;
   logic                cmd_write;
   logic                start;       // Valid burst command on update
   logic                op_ld;
   logic                next_word;   // Load the next read word into the output shift

   assign op_in     = data_register_i[62:59];
   assign cmd_write = op_in inside {[dbg_pkg::BWRITE8:dbg_pkg::BWRITE64]};
   assign cmd_read  = op_in inside {[dbg_pkg::BREAD8:dbg_pkg::BREAD64]};
   assign start     = update_dr_i & module_select_i & ~data_register_i[63]
                    & (cmd_read | cmd_write);

   ////////////////////////////////////////////////////////////
   // State and opcode registers
   always_ff @(posedge tck_i or negedge trstn_i)
   begin
      if (!trstn_i)
      begin
         state_q <= dbg_pkg::IDLE;
         op_q    <= dbg_pkg::BWRITE8;
      end
      else
      begin
         state_q <= state_d;
         if (op_ld)
            op_q <= dbg_pkg::cmd_op_e'(op_in);
      end
   end

   assign op_o = op_q;
   assign top_inhibit_o = state_q inside {dbg_pkg::RSTATUS, dbg_pkg::RBURST, dbg_pkg::RCRC,
      dbg_pkg::WWAIT, dbg_pkg::WBURST, dbg_pkg::WCRC, dbg_pkg::WMATCH};

   ////////////////////////////////////////////////////////////
   // Next state and strobes
   always_comb
   begin
      state_d        = state_q;
      ctrl_o         = '0;
      ctrl_o.tdo_sel = dbg_pkg::DATA;  // Default source, output shift LSB
      op_ld          = 1'b0;
      next_word      = 1'b0;
      case (state_q)
         dbg_pkg::IDLE:
            if (start)
            begin
               op_ld          = 1'b1;
               ctrl_o.addr_ld = 1'b1;
               ctrl_o.word_ld = 1'b1;
               ctrl_o.bit_clr = 1'b1;
               ctrl_o.crc_clr = 1'b1;
               state_d        = cmd_read ? dbg_pkg::RBEGIN : dbg_pkg::WREADY;
            end
         dbg_pkg::RBEGIN:
            if (stat_i.word_zero)
               state_d = dbg_pkg::IDLE;      // Empty burst
            else
            begin
               ctrl_o.bus_strobe = 1'b1;     // Prefetch the first word
               ctrl_o.addr_inc   = 1'b1;
               state_d           = dbg_pkg::RREADY;
            end
         dbg_pkg::RREADY:
            if (module_select_i && capture_dr_i)
               state_d = dbg_pkg::RSTATUS;
         dbg_pkg::RSTATUS:
         begin
            ctrl_o.tdo_sel = dbg_pkg::STATUS;  // Host polls this bit
            if (shift_dr_i && bus_rdy_i)
            begin
               next_word = 1'b1;
               state_d   = dbg_pkg::RBURST;
            end
         end
         dbg_pkg::RBURST:
            if (shift_dr_i)
            begin
               ctrl_o.out_shift = 1'b1;
               ctrl_o.bit_inc   = 1'b1;
               ctrl_o.crc_en    = 1'b1;      // CRC over the bit leaving on TDO
               if (stat_i.bit_max && stat_i.word_zero)
                  state_d = dbg_pkg::RCRC;
               else if (stat_i.bit_max)
                  next_word = 1'b1;
            end
         dbg_pkg::RCRC:
         begin
            ctrl_o.tdo_sel   = dbg_pkg::CRC;
            ctrl_o.crc_shift = shift_dr_i;   // Stays here until update
         end
         dbg_pkg::WREADY:
            if (stat_i.word_zero)
               state_d = dbg_pkg::IDLE;
            else if (module_select_i && capture_dr_i)
               state_d = dbg_pkg::WWAIT;
         dbg_pkg::WWAIT:
            // Start bit at DR[63], first data bit is on TDI now
            if (shift_dr_i && module_select_i && data_register_i[63])
            begin
               ctrl_o.bit_inc     = 1'b1;
               ctrl_o.word_dec    = 1'b1;    // Count is pre-decremented
               ctrl_o.crc_en      = 1'b1;
               ctrl_o.crc_tdi_sel = 1'b1;
               state_d            = dbg_pkg::WBURST;
            end
         dbg_pkg::WBURST:
            if (shift_dr_i)
            begin
               ctrl_o.bit_inc     = 1'b1;
               ctrl_o.crc_en      = 1'b1;
               ctrl_o.crc_tdi_sel = 1'b1;
               if (stat_i.bit_max)
               begin
                  ctrl_o.bit_clr    = 1'b1;
                  ctrl_o.bus_strobe = 1'b1;  // Word complete, write it out
                  ctrl_o.addr_inc   = 1'b1;
                  if (stat_i.word_zero)
                     state_d = dbg_pkg::WCRC;
                  else
                     ctrl_o.word_dec = 1'b1;
               end
            end
         dbg_pkg::WCRC:
            if (stat_i.bit_32)
            begin
               ctrl_o.tdo_sel = dbg_pkg::MATCH;  // All 32 CRC bits are in the DR
               state_d        = dbg_pkg::WMATCH;
            end
            else
               ctrl_o.bit_inc = shift_dr_i;
         dbg_pkg::WMATCH:
            ctrl_o.tdo_sel = dbg_pkg::MATCH;
         default:
            state_d = dbg_pkg::IDLE;
      endcase

      // Shared by RSTATUS and RBURST
      if (next_word)
      begin
         ctrl_o.out_ld   = 1'b1;
         ctrl_o.bit_clr  = 1'b1;
         ctrl_o.word_dec = 1'b1;
         if (!stat_i.last_word)
         begin
            ctrl_o.bus_strobe = 1'b1;  // Fetch the following word meanwhile
            ctrl_o.addr_inc   = 1'b1;
         end
      end

      // Host ended the burst early
      if (update_dr_i && !(state_q inside {dbg_pkg::IDLE, dbg_pkg::RBEGIN}))
         state_d = dbg_pkg::IDLE;
   end

   a_state_legal: assert property (@(posedge tck_i) disable iff (!trstn_i)
      state_q inside {[dbg_pkg::IDLE:dbg_pkg::WMATCH]})
      else $error("burst FSM left its state encoding");

endmodule

/* logic/dbg_counters.sv */
`timescale 1ns/1ns

module dbg_counters (
   input  logic                     tck_i,
   input  logic                     trstn_i,
   input  dbg_pkg::ctrl_t           ctrl_i,
   input  dbg_pkg::cmd_op_e         op_i,
   input  logic [dbg_pkg::DR_W-1:0] data_register_i,
   output dbg_pkg::addr_t           addr_o,
   output dbg_pkg::cnt_stat_t       stat_o
);

   dbg_pkg::addr_t     addr_q;
   dbg_pkg::word_cnt_t word_q;    // Words still to move
   dbg_pkg::bit_cnt_t  bit_q;
   dbg_pkg::bit_cnt_t  bit_last;  // Word bits minus 1

   assign bit_last = dbg_pkg::bit_cnt_t'({dbg_pkg::word_bytes(op_i), 3'b000} - 7'd1);

   always_ff @(posedge tck_i or negedge trstn_i)
   begin
      if (!trstn_i)
      begin
         addr_q <= '0;
         word_q <= '0;
         bit_q  <= '0;
      end
      else
      begin
         if (ctrl_i.addr_ld)
            addr_q <= data_register_i[58:27];  // Start address
         else if (ctrl_i.addr_inc)
            addr_q <= addr_q + dbg_pkg::addr_t'(dbg_pkg::word_bytes(op_i));

         if (ctrl_i.word_ld)
            word_q <= data_register_i[26:11];  // Word count
         else if (ctrl_i.word_dec)
            word_q <= word_q - 16'd1;

         if (ctrl_i.bit_clr)                  // Clear wins over increment
            bit_q <= '0;
         else if (ctrl_i.bit_inc)
            bit_q <= bit_q + 6'd1;
      end
   end

   assign addr_o           = addr_q;
   assign stat_o.word_zero = (word_q == 16'd0);
   assign stat_o.last_word = (word_q == 16'd1);
   assign stat_o.bit_max   = (bit_q == bit_last);
   assign stat_o.bit_32    = (bit_q == 6'd32);  // CRC fully shifted in

endmodule

/* logic/dbg_out_shift.sv */
`timescale 1ns/1ns

module dbg_out_shift (
   input  logic           tck_i,
   input  logic           trstn_i,
   input  dbg_pkg::ctrl_t ctrl_i,
   input  dbg_pkg::data_t load_data_i,
   output logic           bit_o
);

   dbg_pkg::data_t shift_q;

   // Parallel load has priority over the shift
   always_ff @(posedge tck_i or negedge trstn_i)
   begin
      if (!trstn_i)
         shift_q <= '0;
      else if (ctrl_i.out_ld)
         shift_q <= load_data_i;
      else if (ctrl_i.out_shift)
         shift_q <= {1'b0, shift_q[dbg_pkg::DATA_W-1:1]};  // LSB first, zero fill
   end

   assign bit_o = shift_q[0];  // To TDO and the CRC

endmodule

/* logic/dbg_crc32.sv */
`timescale 1ns/1ns

module dbg_crc32 (
   input  logic           tck_i,
   input  logic           trstn_i,
   input  dbg_pkg::ctrl_t ctrl_i,
   input  logic           tdi_i,
   input  logic           read_bit_i,
   output dbg_pkg::crc_t  crc_o,
   output logic           serial_o
);

   dbg_pkg::crc_t crc_q;
   logic          crc_bit;  // Write data or read data
   logic          fb;

   assign crc_bit = ctrl_i.crc_tdi_sel ? tdi_i : read_bit_i;
   assign fb      = crc_q[0] ^ crc_bit;

   always_ff @(posedge tck_i or negedge trstn_i)
   begin
      if (!trstn_i)
         crc_q <= dbg_pkg::CRC_INIT;
      else if (ctrl_i.crc_clr)
         crc_q <= dbg_pkg::CRC_INIT;      // New burst
      else if (ctrl_i.crc_en)
         crc_q <= (crc_q >> 1) ^ ({dbg_pkg::CRC_W{fb}} & dbg_pkg::CRC_POLY);
      else if (ctrl_i.crc_shift)
         crc_q <= crc_q >> 1;             // Acts as its own output shift
   end

   assign crc_o    = crc_q;
   assign serial_o = crc_q[0];

endmodule

/* logic/dbg_bus_master.sv */
`timescale 1ns/1ns

module dbg_bus_master (
   input  logic                     tck_i,
   input  logic                     trstn_i,
   input  dbg_pkg::ctrl_t           ctrl_i,
   input  dbg_pkg::cmd_op_e         op_i,
   input  dbg_pkg::addr_t           addr_i,
   input  logic                     tdi_i,
   input  logic [dbg_pkg::DR_W-1:0] data_register_i,
   output dbg_pkg::bus_req_t        bus_req_o,
   output logic                     bus_req_valid_o,
   input  logic                     bus_req_ready_i,
   input  logic                     bus_rsp_valid_i,
   input  dbg_pkg::data_t           bus_rsp_data_i,
   output dbg_pkg::data_t           rdata_o,
   output logic                     rdy_o
);

   dbg_pkg::bus_req_t req_q;
   dbg_pkg::data_t    rdata_q;
   dbg_pkg::data_t    shifted_in;  // Newest bit on top
   dbg_pkg::data_t    rsp_mask;    // Low size*8 bits
   dbg_pkg::size_t    size;
   logic [6:0]        word_bits;
   logic              valid_q;
   logic              rdy_q;
   logic              accept;      // Request handshake this cycle
   logic              rsp_done;

   assign size       = dbg_pkg::word_bytes(op_i);
   assign word_bits  = {size, 3'b000};
   assign shifted_in = {tdi_i, data_register_i[dbg_pkg::DR_W-1:1]};
   assign rsp_mask   = {dbg_pkg::DATA_W{1'b1}} >> (7'd64 - {req_q.size, 3'b000});
   assign accept     = valid_q & bus_req_ready_i;
   assign rsp_done   = bus_rsp_valid_i & ~rdy_q & ~req_q.write;

   ////////////////////////////////////////////////////////////
   // Request payload and read data
   always_ff @(posedge tck_i)
   begin
      if (ctrl_i.bus_strobe)
      begin
         req_q.addr  <= addr_i;
         req_q.wdata <= shifted_in >> (7'd64 - word_bits);  // Right-align the word
         req_q.size  <= size;
         req_q.write <= (op_i < dbg_pkg::BREAD8);
      end
      if (rsp_done)
         rdata_q <= bus_rsp_data_i & rsp_mask;
   end

   ////////////////////////////////////////////////////////////
   // Handshake and ready flag
   always_ff @(posedge tck_i or negedge trstn_i)
   begin
      if (!trstn_i)
      begin
         valid_q <= 1'b0;
         rdy_q   <= 1'b1;
      end
      else if (ctrl_i.bus_strobe)
      begin
         valid_q <= 1'b1;
         rdy_q   <= 1'b0;
      end
      else
      begin
         if (accept)
            valid_q <= 1'b0;
         if ((accept && req_q.write) || rsp_done)  // Write ends on acceptance
            rdy_q <= 1'b1;
      end
   end

   assign bus_req_o       = req_q;
   assign bus_req_valid_o = valid_q;
   assign rdata_o         = rdata_q;
   assign rdy_o           = rdy_q;

   // Word timing of the burst must leave room for the bus to finish
   a_no_strobe_busy: assert property (@(posedge tck_i) disable iff (!trstn_i)
      ctrl_i.bus_strobe |-> rdy_q)
      else $error("bus strobe while a transaction is in flight");

   a_req_stable: assert property (@(posedge tck_i) disable iff (!trstn_i)
      bus_req_valid_o && !bus_req_ready_i |=> bus_req_valid_o && $stable(bus_req_o))
      else $error("bus request changed under back-pressure");

endmodule

/* logic/dbg_axi_module.sv */
`timescale 1ns/1ns

module dbg_axi_module (
   input  logic                     tck_i,
   input  logic                     trstn_i,
   input  logic                     tdi_i,
   input  logic                     capture_dr_i,
   input  logic                     shift_dr_i,
   input  logic                     update_dr_i,
   input  logic                     module_select_i,
   input  logic [dbg_pkg::DR_W-1:0] data_register_i,
   output logic                     module_tdo_o,
   output logic                     top_inhibit_o,
   output dbg_pkg::bus_req_t        bus_req_o,
   output logic                     bus_req_valid_o,
   input  logic                     bus_req_ready_i,
   input  logic                     bus_rsp_valid_i,
   input  dbg_pkg::data_t           bus_rsp_data_i
);

   dbg_pkg::ctrl_t     ctrl;
   dbg_pkg::cnt_stat_t stat;
   dbg_pkg::cmd_op_e   op;
   dbg_pkg::addr_t     addr;
   dbg_pkg::data_t     rdata;
   dbg_pkg::crc_t      crc;
   logic               bus_rdy;
   logic               out_bit;
   logic               crc_serial;
   logic               crc_match;  // Host CRC in DR[63:32] equals ours

   dbg_cmd_fsm u_fsm (
      .tck_i, .trstn_i, .module_select_i, .capture_dr_i, .update_dr_i, .shift_dr_i,
      .data_register_i, .stat_i(stat), .bus_rdy_i(bus_rdy), .ctrl_o(ctrl), .op_o(op),
      .top_inhibit_o
   );

   dbg_counters u_cnt (
      .tck_i, .trstn_i, .ctrl_i(ctrl), .op_i(op), .data_register_i,
      .addr_o(addr), .stat_o(stat)
   );

   dbg_out_shift u_out (.tck_i, .trstn_i, .ctrl_i(ctrl), .load_data_i(rdata), .bit_o(out_bit));

   dbg_crc32 u_crc (
      .tck_i, .trstn_i, .ctrl_i(ctrl), .tdi_i, .read_bit_i(out_bit),
      .crc_o(crc), .serial_o(crc_serial)
   );

   dbg_bus_master u_bus (
      .tck_i, .trstn_i, .ctrl_i(ctrl), .op_i(op), .addr_i(addr), .tdi_i, .data_register_i,
      .bus_req_o, .bus_req_valid_o, .bus_req_ready_i, .bus_rsp_valid_i, .bus_rsp_data_i,
      .rdata_o(rdata), .rdy_o(bus_rdy)
   );

   ////////////////////////////////////////////////////////////
   // TDO source select
   assign crc_match = (data_register_i[63:32] == crc);

   always_comb
   begin
      case (ctrl.tdo_sel)
         dbg_pkg::STATUS: module_tdo_o = bus_rdy;     // Read poll bit
         dbg_pkg::MATCH:  module_tdo_o = crc_match;
         dbg_pkg::CRC:    module_tdo_o = crc_serial;
         default:         module_tdo_o = out_bit;     // Read data
      endcase
   end

endmodule

/* verif/tb_dbg_tasks.svh */
`ifndef TB_DBG_TASKS_SVH
`define TB_DBG_TASKS_SVH

////////////////////////////////////////////////////////////
// Failure reporting and compare tasks
task automatic stop_on_error(input string why);
   errors++;
   $display("%s", why);
   $display("Done: errors found");
   $fatal(1);
endtask

task automatic check_addr(input string what, input dbg_pkg::addr_t got, input dbg_pkg::addr_t exp);
   if (got !== exp)
      stop_on_error($sformatf("mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp));
endtask

task automatic check_data(input string what, input dbg_pkg::data_t got, input dbg_pkg::data_t exp);
   if (got !== exp)
      stop_on_error($sformatf("mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp));
endtask

task automatic check_crc(input string what, input dbg_pkg::crc_t got, input dbg_pkg::crc_t exp);
   if (got !== exp)
      stop_on_error($sformatf("mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp));
endtask

task automatic check_size(input string what, input dbg_pkg::size_t got, input dbg_pkg::size_t exp);
   if (got !== exp)
      stop_on_error($sformatf("mismatch at %0t ns: %s is %0d, expected %0d", $time, what, got, exp));
endtask

task automatic check_bit(input string what, input logic got, input logic exp);
   if (got !== exp)
      stop_on_error($sformatf("mismatch at %0t ns: %s is %b, expected %b", $time, what, got, exp));
endtask

////////////////////////////////////////////////////////////
// Reference model
function automatic int op_bytes(input dbg_pkg::cmd_op_e op);
   return 1 << ((int'(op) - 1) % 4);  // Sizes repeat for reads
endfunction

function automatic dbg_pkg::crc_t crc_step(input dbg_pkg::crc_t c, input logic b);
   return (c >> 1) ^ (((c[0] ^ b) == 1'b1) ? dbg_pkg::CRC_POLY : 32'h0);
endfunction

function automatic logic [63:0] make_cmd(input dbg_pkg::cmd_op_e op, input dbg_pkg::addr_t a,
                                         input int n);
   return {1'b0, op, a, 16'(n), 11'h0};  // Bit 63 clear for a module command
endfunction

// One TCK cycle driven on the falling edge, TDO taken after it settles
task automatic jtag_cycle(input logic sh, input logic cap, input logic upd, input logic b,
                          output logic tdo);
   @(negedge tck_i);
   shift_dr_i      = sh;
   capture_dr_i    = cap;
   update_dr_i     = upd;
   tdi_i           = b;
   data_register_i = dr;
   #1 tdo = module_tdo_o;
   if (sh)
      dr = {b, dr[63:1]};  // DR contents after the coming edge
endtask

task automatic check_requests(input dbg_pkg::data_t exp_words[$], input dbg_pkg::addr_t addr,
                              input dbg_pkg::cmd_op_e op, input logic write);
   int b;
   b = op_bytes(op);
   if (req_log.size() != exp_words.size())
      stop_on_error($sformatf("expected %0d bus requests but the bus saw %0d",
                              exp_words.size(), req_log.size()));
   foreach (exp_words[k])
   begin
      check_addr("request address", req_log[k].addr, addr + dbg_pkg::addr_t'(k * b));
      check_bit("request write flag", req_log[k].write, write);
      check_size("request size", req_log[k].size, dbg_pkg::size_t'(b));
      if (write)
         check_data("write data", req_log[k].wdata, exp_words[k]);
   end
endtask

////////////////////////////////////////////////////////////
// Host bursts
task automatic write_burst(input dbg_pkg::cmd_op_e op, input dbg_pkg::addr_t addr, input int n,
                           input logic flip_crc);
   dbg_pkg::data_t words[$];
   dbg_pkg::data_t val;
   dbg_pkg::crc_t  crc;
   dbg_pkg::crc_t  sent;
   int             w;
   logic           tdo;
   w   = op_bytes(op) * 8;
   crc = dbg_pkg::CRC_INIT;
   for (int k = 0; k < n; k++)
   begin
      val = {$urandom, $urandom};
      if (w < 64)
         val = val & ((64'd1 << w) - 64'd1);
      words.push_back(val);
      for (int j = 0; j < w; j++)
         crc = crc_step(crc, val[j]);
   end
   req_log.delete();
   dr = make_cmd(op, addr, n);
   jtag_cycle(1'b0, 1'b0, 1'b1, 1'b0, tdo);  // Command accepted
   jtag_cycle(1'b0, 1'b1, 1'b0, 1'b0, tdo);
   jtag_cycle(1'b1, 1'b0, 1'b0, 1'b1, tdo);  // Start bit
   foreach (words[k])
      for (int j = 0; j < w; j++)
         jtag_cycle(1'b1, 1'b0, 1'b0, words[k][j], tdo);
   sent = flip_crc ? crc ^ (32'd1 << ($urandom % 32)) : crc;
   for (int j = 0; j < 32; j++)
      jtag_cycle(1'b1, 1'b0, 1'b0, sent[j], tdo);  // CRC LSB first
   jtag_cycle(1'b0, 1'b0, 1'b0, 1'b0, tdo);
   check_bit("write CRC match bit", tdo, !flip_crc);
   check_bit("top_inhibit_o at match", top_inhibit_o, 1'b1);
   jtag_cycle(1'b0, 1'b0, 1'b1, 1'b0, tdo);
   check_requests(words, addr, op, 1'b1);
endtask

task automatic read_burst(input dbg_pkg::cmd_op_e op, input dbg_pkg::addr_t addr, input int n);
   dbg_pkg::data_t exp_words[$];
   dbg_pkg::data_t val;
   dbg_pkg::data_t got;
   dbg_pkg::crc_t  crc;
   dbg_pkg::crc_t  got_crc;
   int             w;
   int             polls;
   logic           tdo;
   w   = op_bytes(op) * 8;
   crc = dbg_pkg::CRC_INIT;
   for (int k = 0; k < n; k++)
   begin
      val = mem_word(addr + dbg_pkg::addr_t'(k * op_bytes(op)), op_bytes(op));
      exp_words.push_back(val);
      for (int j = 0; j < w; j++)
         crc = crc_step(crc, val[j]);
   end
   req_log.delete();
   dr = make_cmd(op, addr, n);
   jtag_cycle(1'b0, 1'b0, 1'b1, 1'b0, tdo);
   jtag_cycle(1'b0, 1'b0, 1'b0, 1'b0, tdo);  // First read goes out
   jtag_cycle(1'b0, 1'b1, 1'b0, 1'b0, tdo);
   polls = 0;
   tdo   = 1'b0;
   while (tdo !== 1'b1)
   begin
      if (polls == 16)
         stop_on_error("read status bit did not come up within 16 polls");
      jtag_cycle(1'b1, 1'b0, 1'b0, 1'b0, tdo);
      polls++;
   end
   check_bit("top_inhibit_o while reading", top_inhibit_o, 1'b1);
   foreach (exp_words[k])
   begin
      got = '0;
      for (int j = 0; j < w; j++)
      begin
         jtag_cycle(1'b1, 1'b0, 1'b0, 1'b0, tdo);
         got[j] = tdo;
      end
      check_data("read word", got, exp_words[k]);
   end
   for (int j = 0; j < 32; j++)
   begin
      jtag_cycle(1'b1, 1'b0, 1'b0, 1'b0, tdo);
      got_crc[j] = tdo;
   end
   check_crc("read CRC", got_crc, crc);
   jtag_cycle(1'b0, 1'b0, 1'b1, 1'b0, tdo);
   check_requests(exp_words, addr, op, 1'b0);
endtask

task automatic zero_count_burst(input dbg_pkg::cmd_op_e op);
   logic tdo;
   req_log.delete();
   dr = make_cmd(op, $urandom, 0);
   jtag_cycle(1'b0, 1'b0, 1'b1, 1'b0, tdo);
   jtag_cycle(1'b0, 1'b0, 1'b0, 1'b0, tdo);
   jtag_cycle(1'b0, 1'b1, 1'b0, 1'b0, tdo);
   repeat (6)
      jtag_cycle(1'b0, 1'b0, 1'b0, 1'b0, tdo);
   check_bit("top_inhibit_o after empty burst", top_inhibit_o, 1'b0);
   check_bit("bus_req_valid_o after empty burst", bus_req_valid_o, 1'b0);
   if (req_log.size() != 0)
      stop_on_error("a burst with a word count of zero put a request on the bus");
endtask

// Update in the middle of a 32-bit write, one word already out
task automatic abort_burst();
   logic tdo;
   req_log.delete();
   dr = make_cmd(dbg_pkg::BWRITE32, $urandom, 4);
   jtag_cycle(1'b0, 1'b0, 1'b1, 1'b0, tdo);
   jtag_cycle(1'b0, 1'b1, 1'b0, 1'b0, tdo);
   jtag_cycle(1'b1, 1'b0, 1'b0, 1'b1, tdo);
   repeat (40)
      jtag_cycle(1'b1, 1'b0, 1'b0, 1'($urandom), tdo);
   check_bit("top_inhibit_o inside burst", top_inhibit_o, 1'b1);
   jtag_cycle(1'b0, 1'b0, 1'b1, 1'b0, tdo);
   jtag_cycle(1'b0, 1'b0, 1'b0, 1'b0, tdo);
   check_bit("top_inhibit_o after early update", top_inhibit_o, 1'b0);
   repeat (8)
      jtag_cycle(1'b0, 1'b0, 1'b0, 1'b0, tdo);
   if (req_log.size() != 1)
      stop_on_error("the aborted burst did not write exactly its one finished word");
endtask

`endif

/* verif/tb_dbg_axi_module.sv */
`timescale 1ns/1ns

module tb_dbg_axi_module;

   localparam int N_WR        = 12;                // Random write bursts
   localparam int N_RD        = 12;                // Random read bursts
   localparam int BURST_BITS  = 8 * 64 + 32 + 64;  // Words, CRC, polls and command cycles
   localparam int WATCHDOG_NS = (N_WR + N_RD + 4) * BURST_BITS * 8 * 4;

   logic                     tck_i;
   logic                     trstn_i;
   logic                     tdi_i;
   logic                     capture_dr_i;
   logic                     shift_dr_i;
   logic                     update_dr_i;
   logic                     module_select_i;
   logic [dbg_pkg::DR_W-1:0] data_register_i;
   logic                     module_tdo_o;
   logic                     top_inhibit_o;
   dbg_pkg::bus_req_t        bus_req_o;
   logic                     bus_req_valid_o;
   logic                     bus_req_ready_i;
   logic                     bus_rsp_valid_i;
   dbg_pkg::data_t           bus_rsp_data_i;

   logic [dbg_pkg::DR_W-1:0] dr;                   // TAP data register model
   dbg_pkg::bus_req_t        req_log[$];           // Requests seen by the slave
   logic [7:0]               mem[dbg_pkg::addr_t]; // Sparse byte memory
   int                       errors;

   dbg_axi_module dut (.*);

   initial
   begin
      tck_i = 1'b0;
      forever #4 tck_i = ~tck_i;  // 8 ns period
   end

   // Unwritten bytes follow a pattern folded from all address bits
   function automatic dbg_pkg::data_t mem_word(input dbg_pkg::addr_t a, input int bytes);
      dbg_pkg::data_t v;
      dbg_pkg::addr_t b;
      v = '0;
      for (int i = 0; i < bytes; i++)
      begin
         b = a + dbg_pkg::addr_t'(i);
         v[8*i +: 8] = mem.exists(b) ? mem[b] : (b[31:24] ^ b[23:16] ^ b[15:8] ^ b[7:0] ^ 8'h5a);
      end
      return v;
   endfunction

   ////////////////////////////////////////////////////////////
   // Bus slave with random ready and response delays
   initial
   begin : bus_slave
      int                d_req;
      int                d_rsp;
      dbg_pkg::bus_req_t req;
      bus_req_ready_i = 1'b0;
      bus_rsp_valid_i = 1'b0;
      bus_rsp_data_i  = '0;
      forever
      begin
         @(negedge tck_i);
         if (bus_req_valid_o === 1'b1)
         begin
            d_req = $urandom % 5;
            d_rsp = $urandom % (5 - d_req);  // Keeps the whole transaction short
            repeat (d_req) @(negedge tck_i);
            req             = bus_req_o;
            bus_req_ready_i = 1'b1;
            @(negedge tck_i);                // Accepted on the edge in between
            bus_req_ready_i = 1'b0;
            req_log.push_back(req);
            if (req.write)
            begin
               for (int i = 0; i < req.size; i++)
                  mem[req.addr + dbg_pkg::addr_t'(i)] = req.wdata[8*i +: 8];
            end
            else
            begin
               repeat (d_rsp) @(negedge tck_i);
               // Junk above the word checks the master's masking
               bus_rsp_data_i  = ({$urandom, $urandom} << (8 * req.size))
                               | mem_word(req.addr, req.size);
               bus_rsp_valid_i = 1'b1;
               @(negedge tck_i);
               bus_rsp_valid_i = 1'b0;
            end
         end
      end
   end

`include "tb_dbg_tasks.svh"

   initial
   begin
      #(WATCHDOG_NS);
      stop_on_error("watchdog expired before the test sequence finished");
   end

   ////////////////////////////////////////////////////////////
   // Test sequence
   initial
   begin : sequence_main
      dbg_pkg::addr_t   addr;
      dbg_pkg::addr_t   last_wr;
      dbg_pkg::cmd_op_e op;
      int               i;
      void'($urandom(32'hf735_84d8));
      errors          = 0;
      dr              = '0;
      trstn_i         = 1'b0;
      tdi_i           = 1'b0;
      capture_dr_i    = 1'b0;
      shift_dr_i      = 1'b0;
      update_dr_i     = 1'b0;
      module_select_i = 1'b1;        // This module stays selected
      data_register_i = '0;
      repeat (5) @(posedge tck_i);
      @(negedge tck_i);
      trstn_i = 1'b1;
      #1;
      check_bit("module_tdo_o after reset", module_tdo_o, 1'b0);
      check_bit("top_inhibit_o after reset", top_inhibit_o, 1'b0);
      check_bit("bus_req_valid_o after reset", bus_req_valid_o, 1'b0);

      last_wr = '0;
      for (i = 0; i < N_WR; i++)
      begin
         op      = dbg_pkg::cmd_op_e'(1 + i % 4);  // Every write size in turn
         last_wr = $urandom;
         write_burst(op, last_wr, 1 + $urandom % 8, 1'b0);
      end
      write_burst(dbg_pkg::BWRITE16, $urandom, 1 + $urandom % 8, 1'b1);  // Bad CRC

      for (i = 0; i < N_RD; i++)
      begin
         op   = dbg_pkg::cmd_op_e'(5 + i % 4);
         addr = (i % 2) ? last_wr : dbg_pkg::addr_t'($urandom);  // Half read back written data
         read_burst(op, addr, 1 + $urandom % 8);
      end

      zero_count_burst(dbg_pkg::BWRITE32);
      zero_count_burst(dbg_pkg::BREAD16);
      abort_burst();

      if (errors == 0)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   end

endmodule

/* dbg_axi_module.f */
+incdir+verif
logic/dbg_pkg.sv
logic/dbg_cmd_fsm.sv
logic/dbg_counters.sv
logic/dbg_out_shift.sv
logic/dbg_crc32.sv
logic/dbg_bus_master.sv
logic/dbg_axi_module.sv
verif/tb_dbg_axi_module.sv

/* Bender.yml */
package:
  name: dbg_axi_module

sources:
  - logic/dbg_pkg.sv
  - logic/dbg_cmd_fsm.sv
  - logic/dbg_counters.sv
  - logic/dbg_out_shift.sv
  - logic/dbg_crc32.sv
  - logic/dbg_bus_master.sv
  - logic/dbg_axi_module.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tb_dbg_axi_module.sv
